//--- Bender.yml
package:
  name: processorci

sources:
  - files:
      - hw/rv_pkg.sv
      - hw/rv_regfile.sv
      - hw/rv_core.sv
      - hw/wb_data_port.sv
      - hw/processorci_top.sv
  - target: test
    files:
      - bench/wb_mem_model.sv
      - bench/processorci_asserts.sv
      - bench/tb_processorci.sv

//--- bench/processorci_asserts.sv
`timescale 1ns/1ns

module processorci_asserts import rv_pkg::*; (
    input logic            sys_clk_i,
    input logic            reset_i,
    input logic            instr_cyc_i,
    input logic            instr_stb_i,
    input logic [XLEN-1:0] instr_adr_i,
    input logic            instr_ack_i,
    input logic            data_cyc_i,
    input logic            data_stb_i,
    input logic            data_we_i,
    input logic [XLEN-1:0] data_adr_i,
    input logic [XLEN-1:0] data_dat_i,
    input logic            data_ack_i,
    input core_state_e     state_i,
    input logic            exp_valid_i,
    input logic [XLEN-1:0] exp_adr_i,
    input logic [XLEN-1:0] exp_dat_i
);

    int fail_cnt = 0; // Number of failed checks so far

    reset_quiet: assert property (@(posedge sys_clk_i)
        reset_i |=> !instr_cyc_i && !instr_stb_i && !data_cyc_i && !data_stb_i && !data_we_i)
        else begin
            fail_cnt++;
            $error("bus active while reset held");
        end

    // First fetch right after reset
    first_fetch: assert property (@(posedge sys_clk_i)
        $fell(reset_i) |=> instr_stb_i && (instr_adr_i == RESET_PC))
        else begin
            fail_cnt++;
            $error("first fetch missing or not at reset vector");
        end

    cyc_matches_stb: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        (instr_cyc_i == instr_stb_i) && (data_cyc_i == data_stb_i))
        else begin
            fail_cnt++;
            $error("cyc and stb differ");
        end

    instr_hold: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        instr_stb_i && !instr_ack_i |=> instr_stb_i && $stable(instr_adr_i))
        else begin
            fail_cnt++;
            $error("instruction request changed before ack");
        end

    data_hold: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        data_stb_i && !data_ack_i |=> data_stb_i && $stable(data_adr_i) &&
                                      $stable(data_we_i) && $stable(data_dat_i))
        else begin
            fail_cnt++;
            $error("data request changed before ack");
        end

    // Classic cycle closes right after ack
    instr_release: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        instr_stb_i && instr_ack_i |=> !instr_stb_i)
        else begin
            fail_cnt++;
            $error("instruction stb held after ack");
        end

    data_release: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        data_stb_i && data_ack_i |=> !data_stb_i)
        else begin
            fail_cnt++;
            $error("data stb held after ack");
        end

    exec_one_cycle: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        (state_i == EXEC) |=> (state_i != EXEC))
        else begin
            fail_cnt++;
            $error("EXEC lasted more than one cycle");
        end

    data_in_mem: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        data_stb_i |-> (state_i == MEM))
        else begin
            fail_cnt++;
            $error("data access outside MEM state");
        end

    // Each write in order against the expected table
    store_check: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        data_stb_i && data_we_i && data_ack_i |->
            exp_valid_i && (data_adr_i == exp_adr_i) && (data_dat_i == exp_dat_i))
        else begin
            fail_cnt++;
            $error("unexpected store %h <= %h", data_adr_i, data_dat_i);
        end

endmodule

//--- bench/tb_processorci.sv
`timescale 1ns/1ns

module tb_processorci import rv_pkg::*; ();

    localparam int RESET_CYCLES    = 10;
    localparam int NUM_STORES      = 8;
    localparam int DYN_INSTR       = 30; // Retired before the final self-loop
    localparam int MAX_INSTR_CYC   = 16; // Fetch and data access both at 3 wait states
    localparam int WATCHDOG_CYCLES = 4 * (RESET_CYCLES + DYN_INSTR * MAX_INSTR_CYC);
    localparam int DRAIN_CYCLES    = 100;
    localparam logic [31:0] JAL_ADDR = 32'h48;

    logic            sys_clk;
    logic            reset;
    logic            instr_cyc;
    logic            instr_stb;
    logic [XLEN-1:0] instr_adr;
    logic [XLEN-1:0] instr_dat;
    logic            instr_ack;
    logic            data_cyc;
    logic            data_stb;
    logic            data_we;
    logic [XLEN-1:0] data_adr;
    logic [XLEN-1:0] data_wdat;
    logic [XLEN-1:0] data_rdat;
    logic            data_ack;

    int              store_idx = 0;
    logic [31:0]     exp_adr [0:NUM_STORES-1];
    logic [31:0]     exp_dat [0:NUM_STORES-1];
    logic            exp_valid;
    logic [31:0]     exp_adr_cur;
    logic [31:0]     exp_dat_cur;

    assign exp_valid   = (store_idx < NUM_STORES);
    assign exp_adr_cur = exp_valid ? exp_adr[store_idx] : '0;
    assign exp_dat_cur = exp_valid ? exp_dat[store_idx] : '0;

    processorci_top u_processorci_top (
        .sys_clk_i   (sys_clk),
        .reset_i     (reset),
        .instr_cyc_o (instr_cyc),
        .instr_stb_o (instr_stb),
        .instr_adr_o (instr_adr),
        .instr_dat_i (instr_dat),
        .instr_ack_i (instr_ack),
        .data_cyc_o  (data_cyc),
        .data_stb_o  (data_stb),
        .data_we_o   (data_we),
        .data_adr_o  (data_adr),
        .data_dat_o  (data_wdat),
        .data_dat_i  (data_rdat),
        .data_ack_i  (data_ack)
    );

    wb_mem_model u_imem (
        .sys_clk_i (sys_clk),
        .reset_i   (reset),
        .cyc_i     (instr_cyc),
        .stb_i     (instr_stb),
        .we_i      (1'b0),     // Read only
        .adr_i     (instr_adr),
        .dat_i     (32'h0),
        .dat_o     (instr_dat),
        .ack_o     (instr_ack)
    );

    wb_mem_model u_dmem (
        .sys_clk_i (sys_clk),
        .reset_i   (reset),
        .cyc_i     (data_cyc),
        .stb_i     (data_stb),
        .we_i      (data_we),
        .adr_i     (data_adr),
        .dat_i     (data_wdat),
        .dat_o     (data_rdat),
        .ack_o     (data_ack)
    );

    bind processorci_top processorci_asserts u_asserts (
        .sys_clk_i   (sys_clk_i),
        .reset_i     (reset_i),
        .instr_cyc_i (instr_cyc_o),
        .instr_stb_i (instr_stb_o),
        .instr_adr_i (instr_adr_o),
        .instr_ack_i (instr_ack_i),
        .data_cyc_i  (data_cyc_o),
        .data_stb_i  (data_stb_o),
        .data_we_i   (data_we_o),
        .data_adr_i  (data_adr_o),
        .data_dat_i  (data_dat_o),
        .data_ack_i  (data_ack_i),
        .state_i     (u_core.state_q),
        .exp_valid_i (tb_processorci.exp_valid),
        .exp_adr_i   (tb_processorci.exp_adr_cur),
        .exp_dat_i   (tb_processorci.exp_dat_cur)
    );

    // RV32I encodings
    function automatic logic [31:0] lui_word(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] addi_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_OPIMM};
    endfunction

    function automatic logic [31:0] lw_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, OPC_LOAD};
    endfunction

    function automatic logic [31:0] alu_word(logic [6:0] f7, logic [4:0] rd,
                                             logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, 3'b000, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] sw_word(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] branch_word(logic [2:0] f3, logic [4:0] rs1,
                                                logic [4:0] rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic put_instr(logic [31:0] adr, logic [31:0] word);
        u_imem.mem_q[adr[11:2]] = word;
    endtask

    task automatic set_expected(int idx, logic [31:0] adr, logic [31:0] dat);
        exp_adr[idx] = adr;
        exp_dat[idx] = dat;
    endtask

    task automatic clear_memories;
        for (int i = 0; i < 1024; i++) begin
            u_imem.mem_q[i] = '0;
            u_dmem.mem_q[i] = '0;
        end
    endtask

    task automatic load_program;
        put_instr(32'h00, lui_word(5'd1, 20'h12345));
        put_instr(32'h04, addi_word(5'd1, 5'd1, 12'h678));
        put_instr(32'h08, addi_word(5'd2, 5'd0, 12'hffb));      // x2 = -5
        put_instr(32'h0c, alu_word(7'd0, 5'd3, 5'd1, 5'd2));
        put_instr(32'h10, alu_word(F7_SUB, 5'd4, 5'd1, 5'd2));
        put_instr(32'h14, sw_word(5'd1, 5'd0, 12'h100));
        put_instr(32'h18, sw_word(5'd3, 5'd0, 12'h104));
        put_instr(32'h1c, sw_word(5'd4, 5'd0, 12'h108));
        put_instr(32'h20, lw_word(5'd5, 5'd0, 12'h104));        // Read back the ADD result
        put_instr(32'h24, addi_word(5'd5, 5'd5, 12'h001));
        put_instr(32'h28, sw_word(5'd5, 5'd0, 12'h10c));
        put_instr(32'h2c, addi_word(5'd6, 5'd0, 12'h000));
        put_instr(32'h30, addi_word(5'd7, 5'd0, 12'h005));
        put_instr(32'h34, addi_word(5'd6, 5'd6, 12'h001));      // Loop body
        put_instr(32'h38, branch_word(F3_BNE, 5'd6, 5'd7, 13'h1ffc));
        put_instr(32'h3c, sw_word(5'd6, 5'd0, 12'h110));
        put_instr(32'h40, branch_word(F3_BEQ, 5'd6, 5'd2, 13'h0008)); // Not taken
        put_instr(32'h44, sw_word(5'd7, 5'd0, 12'h114));
        put_instr(JAL_ADDR, jal_word(5'd8, 21'd8));
        put_instr(32'h4c, sw_word(5'd0, 5'd0, 12'h1fc));        // Jumped over
        put_instr(32'h50, sw_word(5'd8, 5'd0, 12'h118));
        put_instr(32'h54, addi_word(5'd0, 5'd0, 12'h055));
        put_instr(32'h58, sw_word(5'd0, 5'd0, 12'h11c));
        put_instr(32'h5c, jal_word(5'd0, 21'd0));               // Park here
    endtask

    task automatic build_expected;
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] x3;
        x1 = {20'h12345, 12'h000} + 32'h678;
        x2 = 32'd0 - 32'd5;
        x3 = x1 + x2;
        set_expected(0, 32'h100, x1);
        set_expected(1, 32'h104, x3);
        set_expected(2, 32'h108, x1 - x2);
        set_expected(3, 32'h10c, x3 + 32'd1);
        set_expected(4, 32'h110, 32'd5);
        set_expected(5, 32'h114, 32'd5);
        set_expected(6, 32'h118, JAL_ADDR + 32'd4);
        set_expected(7, 32'h11c, 32'd0);
    endtask

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        if (reset) begin
            store_idx <= 0;
        end else if (data_stb && data_we && data_ack) begin
            store_idx <= store_idx + 1;
        end
    end

    // Stop at the first failed assertion
    always @(negedge sys_clk) begin
        if (u_processorci_top.u_asserts.fail_cnt != 0) begin
            $display("[FAIL] %0t ns: assertion failed in processorci_asserts", $time);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at first assertion failure");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("Timeout after %0d cycles, only %0d of %0d stores seen",
                 WATCHDOG_CYCLES, store_idx, NUM_STORES);
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        reset = 1'b1;
        clear_memories();
        build_expected();
        load_program();
        repeat (RESET_CYCLES) @(negedge sys_clk);
        reset = 1'b0;
        wait (store_idx == NUM_STORES);
        repeat (DRAIN_CYCLES) @(negedge sys_clk); // Any extra store shows up here
        if (u_processorci_top.u_asserts.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("[FAIL] %0t ns: %0d assertion failures", $time,
                     u_processorci_top.u_asserts.fail_cnt);
            $display("SOME TESTS FAILED");
            $fatal(1, "Assertion failures at end of run");
        end
    end

endmodule

//--- bench/wb_mem_model.sv
`timescale 1ns/1ns

module wb_mem_model (
    input  logic        sys_clk_i,
    input  logic        reset_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack_o
);

    logic [31:0] mem_q [0:1023]; // 4 KiB of word-addressed storage
    logic [31:0] rng_q;
    logic [1:0]  wait_q;         // Wait states left for the current request

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        ack_o = 1'b0;
        dat_o = '0;
    end

    // Slave side moves on the falling edge
    always @(negedge sys_clk_i) begin
        if (reset_i) begin
            ack_o  <= 1'b0;
            rng_q  <= 32'd32; // Seed
            wait_q <= 2'd0;
        end else if (ack_o) begin
            ack_o <= 1'b0; // Master has sampled it
        end else if (cyc_i && stb_i) begin
            if (wait_q == 2'd0) begin
                if (we_i) mem_q[adr_i[11:2]] <= dat_i;
                dat_o  <= mem_q[adr_i[11:2]];
                ack_o  <= 1'b1;
                rng_q  <= xorshift32(rng_q);
                wait_q <= rng_q[1:0]; // Delay for the next request
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

endmodule

//--- hw/processorci_top.sv
`timescale 1ns/1ns

module processorci_top import rv_pkg::*; (
    input  logic            sys_clk_i,
    input  logic            reset_i,

    // Read-only instruction bus
    output logic            instr_cyc_o,
    output logic            instr_stb_o,
    output logic [XLEN-1:0] instr_adr_o,
    input  logic [XLEN-1:0] instr_dat_i,
    input  logic            instr_ack_i,

    // Data bus
    output logic            data_cyc_o,
    output logic            data_stb_o,
    output logic            data_we_o,
    output logic [XLEN-1:0] data_adr_o,
    output logic [XLEN-1:0] data_dat_o,
    input  logic [XLEN-1:0] data_dat_i,
    input  logic            data_ack_i
);

    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic            rd_we;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] rd_data;

    logic            mem_req;
    logic            mem_we;
    logic            mem_done;
    logic [XLEN-1:0] mem_adr;
    logic [XLEN-1:0] mem_wdata;
    logic [XLEN-1:0] mem_rdata;

    rv_core u_core (
        .sys_clk_i   (sys_clk_i),
        .reset_i     (reset_i),
        .instr_cyc_o (instr_cyc_o),
        .instr_stb_o (instr_stb_o),
        .instr_adr_o (instr_adr_o),
        .instr_dat_i (instr_dat_i),
        .instr_ack_i (instr_ack_i),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .rd_o        (rd),
        .rd_we_o     (rd_we),
        .rd_data_o   (rd_data),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_adr_o   (mem_adr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .mem_done_i  (mem_done)
    );

    rv_regfile u_regfile (
        .sys_clk_i  (sys_clk_i),
        .reset_i    (reset_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (rd),
        .rd_we_i    (rd_we),
        .rd_data_i  (rd_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    wb_data_port u_data_port (
        .sys_clk_i   (sys_clk_i),
        .reset_i     (reset_i),
        .mem_req_i   (mem_req),
        .mem_we_i    (mem_we),
        .mem_adr_i   (mem_adr),
        .mem_wdata_i (mem_wdata),
        .mem_rdata_o (mem_rdata),
        .mem_done_o  (mem_done),
        .data_cyc_o  (data_cyc_o),
        .data_stb_o  (data_stb_o),
        .data_we_o   (data_we_o),
        .data_adr_o  (data_adr_o),
        .data_dat_o  (data_dat_o),
        .data_dat_i  (data_dat_i),
        .data_ack_i  (data_ack_i)
    );

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
    input  logic            sys_clk_i,
    input  logic            reset_i,

    // Instruction bus master
    output logic            instr_cyc_o,
    output logic            instr_stb_o,
    output logic [XLEN-1:0] instr_adr_o,
    input  logic [XLEN-1:0] instr_dat_i,
    input  logic            instr_ack_i,

    // Register file
    output logic [4:0]      rs1_o,
    output logic [4:0]      rs2_o,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output logic [4:0]      rd_o,
    output logic            rd_we_o,
    output logic [XLEN-1:0] rd_data_o,

    // Load/store request to the data port
    output logic            mem_req_o,
    output logic            mem_we_o,
    output logic [XLEN-1:0] mem_adr_o,
    output logic [XLEN-1:0] mem_wdata_o,
    input  logic [XLEN-1:0] mem_rdata_i,
    input  logic            mem_done_i
);

    core_state_e     state_q;
    logic [XLEN-1:0] pc_q;
    logic            instr_cyc_q;
    logic            wb_en_q;
    logic            mem_req_q;
    logic            mem_we_q;

    instr_u          instr_q;   // Fetched word
    logic [XLEN-1:0] result_q;
    logic [XLEN-1:0] next_pc_q;
    logic [XLEN-1:0] mem_adr_q;
    logic [XLEN-1:0] mem_wdata_q;

    logic [6:0]      opcode;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] exec_result;
    logic [XLEN-1:0] exec_next_pc;
    logic [XLEN-1:0] exec_addr;
    logic            exec_wb;
    logic            exec_mem;
    logic            exec_we;
    logic            rs_equal;

    // Immediates
    assign opcode   = instr_q.raw[6:0];
    assign imm_i    = {{20{instr_q.i.imm[11]}}, instr_q.i.imm};
    assign imm_s    = {{20{instr_q.s.imm_hi[6]}}, instr_q.s.imm_hi, instr_q.s.imm_lo};
    assign imm_u    = {instr_q.raw[31:12], 12'b0};
    assign imm_b    = {{19{instr_q.raw[31]}}, instr_q.raw[31], instr_q.raw[7],
                       instr_q.raw[30:25], instr_q.raw[11:8], 1'b0};
    assign imm_j    = {{11{instr_q.raw[31]}}, instr_q.raw[31], instr_q.raw[19:12],
                       instr_q.raw[20], instr_q.raw[30:21], 1'b0};
    assign pc_plus4 = pc_q + 32'd4;
    assign rs_equal = (rs1_data_i == rs2_data_i);

    always_comb begin
        exec_result  = '0;
        exec_next_pc = pc_plus4; // Default for everything but taken branches and JAL
        exec_addr    = rs1_data_i + imm_i;
        exec_wb      = 1'b0;
        exec_mem     = 1'b0;
        exec_we      = 1'b0;
        case (opcode)
            OPC_LUI: begin
                exec_result = imm_u;
                exec_wb     = 1'b1;
            end
            OPC_OPIMM: begin
                if (instr_q.i.funct3 == 3'b000) begin // ADDI
                    exec_result = rs1_data_i + imm_i;
                    exec_wb     = 1'b1;
                end
            end
            OPC_OP: begin
                if (instr_q.r.funct3 == 3'b000) begin
                    exec_result = (instr_q.r.funct7 == F7_SUB) ? rs1_data_i - rs2_data_i
                                                                : rs1_data_i + rs2_data_i;
                    exec_wb     = 1'b1;
                end
            end
            OPC_LOAD: begin
                if (instr_q.i.funct3 == 3'b010) begin // LW only
                    exec_mem = 1'b1;
                    exec_wb  = 1'b1;
                end
            end
            OPC_STORE: begin
                if (instr_q.s.funct3 == 3'b010) begin // SW only
                    exec_addr = rs1_data_i + imm_s;
                    exec_mem  = 1'b1;
                    exec_we   = 1'b1;
                end
            end
            OPC_BRANCH: begin
                if (((instr_q.s.funct3 == F3_BEQ) && rs_equal) ||
                    ((instr_q.s.funct3 == F3_BNE) && !rs_equal)) begin
                    exec_next_pc = pc_q + imm_b;
                end
            end
            OPC_JAL: begin
                exec_result  = pc_plus4; // Link value
                exec_wb      = 1'b1;
                exec_next_pc = pc_q + imm_j;
            end
            default: ; // Retires as a no-op
        endcase
    end

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            state_q     <= FETCH;
            pc_q        <= RESET_PC;
            instr_cyc_q <= 1'b0;
            wb_en_q     <= 1'b0;
            mem_req_q   <= 1'b0;
            mem_we_q    <= 1'b0;
        end else begin
            mem_req_q <= 1'b0; // Single-cycle pulse
            case (state_q)
                FETCH: begin
                    if (instr_cyc_q && instr_ack_i) begin
                        instr_cyc_q <= 1'b0;
                        state_q     <= EXEC;
                    end else begin
                        instr_cyc_q <= 1'b1;
                    end
                end
                EXEC: begin
                    wb_en_q   <= exec_wb;
                    mem_req_q <= exec_mem;
                    mem_we_q  <= exec_we;
                    state_q   <= exec_mem ? MEM : WB;
                end
                MEM: begin
                    if (mem_done_i) state_q <= WB;
                end
                WB: begin
                    pc_q        <= next_pc_q;
                    instr_cyc_q <= 1'b1; // Next fetch starts right away
                    state_q     <= FETCH;
                end
                default: state_q <= FETCH;
            endcase
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if ((state_q == FETCH) && instr_cyc_q && instr_ack_i) begin
            instr_q.raw <= instr_dat_i;
        end
        if (state_q == EXEC) begin
            result_q    <= exec_result;
            next_pc_q   <= exec_next_pc;
            mem_adr_q   <= exec_addr;
            mem_wdata_q <= rs2_data_i;
        end
        // Load data replaces the ALU result
        if ((state_q == MEM) && mem_done_i && !mem_we_q) begin
            result_q <= mem_rdata_i;
        end
    end

    assign instr_cyc_o = instr_cyc_q;
    assign instr_stb_o = instr_cyc_q;
    assign instr_adr_o = pc_q;

    assign rs1_o     = instr_q.r.rs1;
    assign rs2_o     = instr_q.r.rs2;
    assign rd_o      = instr_q.r.rd;
    assign rd_we_o   = (state_q == WB) && wb_en_q;
    assign rd_data_o = result_q;

    assign mem_req_o   = mem_req_q;
    assign mem_we_o    = mem_we_q;
    assign mem_adr_o   = mem_adr_q;
    assign mem_wdata_o = mem_wdata_q;

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = '0; // First fetch address

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Also serves branches, which share this field layout
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        logic [31:0] raw;
    } instr_u;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        WB
    } core_state_e;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
    input  logic            sys_clk_i,
    input  logic            reset_i,
    input  logic [4:0]      rs1_i,
    input  logic [4:0]      rs2_i,
    input  logic [4:0]      rd_i,
    input  logic            rd_we_i,
    input  logic [XLEN-1:0] rd_data_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o
);

    logic [XLEN-1:0] regs_q [1:31]; // x0 has no storage

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (rd_we_i && (rd_i != 5'd0)) begin
            regs_q[rd_i] <= rd_data_i;
        end
    end

    // Asynchronous read ports
    assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs_q[rs2_i];

endmodule

//--- hw/wb_data_port.sv
`timescale 1ns/1ns

module wb_data_port import rv_pkg::*; (
    input  logic            sys_clk_i,
    input  logic            reset_i,

    input  logic            mem_req_i,
    input  logic            mem_we_i,
    input  logic [XLEN-1:0] mem_adr_i,
    input  logic [XLEN-1:0] mem_wdata_i,
    output logic [XLEN-1:0] mem_rdata_o,
    output logic            mem_done_o,

    output logic            data_cyc_o,
    output logic            data_stb_o,
    output logic            data_we_o,
    output logic [XLEN-1:0] data_adr_o,
    output logic [XLEN-1:0] data_dat_o,
    input  logic [XLEN-1:0] data_dat_i,
    input  logic            data_ack_i
);

    logic            busy_q; // Cycle open on the bus
    logic            we_q;
    logic            done_q;
    logic [XLEN-1:0] adr_q;
    logic [XLEN-1:0] wdat_q;
    logic [XLEN-1:0] rdata_q;

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            we_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                if (mem_req_i) begin
                    busy_q <= 1'b1;
                    we_q   <= mem_we_i;
                end
            end else if (data_ack_i) begin
                busy_q <= 1'b0;
                we_q   <= 1'b0;
                done_q <= 1'b1; // One cycle after ack
            end
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (!busy_q && mem_req_i) begin
            adr_q  <= mem_adr_i;
            wdat_q <= mem_wdata_i;
        end
        if (busy_q && data_ack_i) rdata_q <= data_dat_i;
    end

    assign data_cyc_o  = busy_q;
    assign data_stb_o  = busy_q;
    assign data_we_o   = we_q;
    assign data_adr_o  = adr_q;
    assign data_dat_o  = wdat_q;
    assign mem_rdata_o = rdata_q;
    assign mem_done_o  = done_q;

endmodule

//--- verilog.f
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_core.sv
hw/wb_data_port.sv
hw/processorci_top.sv
bench/wb_mem_model.sv
bench/processorci_asserts.sv
bench/tb_processorci.sv
